// File: bench/axi_mem_model.sv
// AXI slave memory model

module axi_mem_model import bus_pkg::*; #(
  parameter int unsigned Words = 64
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  aw_valid_i,
  output logic  aw_ready_o,
  input  addr_t aw_addr_i,
  input  len_t  aw_len_i,
  input  size_t aw_size_i,
  input  id_t   aw_id_i,
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  addr_t ar_addr_i,
  input  len_t  ar_len_i,
  input  size_t ar_size_i,
  input  id_t   ar_id_i,
  input  logic  w_valid_i,
  output logic  w_ready_o,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  input  logic  w_last_i,
  output logic  b_valid_o,
  input  logic  b_ready_i,
  output id_t   b_id_o,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output data_t r_data_o,
  output id_t   r_id_o,
  output logic  r_last_o
);
  timeunit 1ns;
  timeprecision 1ps;

  data_t       mem [Words];
  logic [31:0] lfsr_q = 32'h77f6;

  // last address phases for the bench to read back
  addr_t last_aw_addr;
  len_t  last_aw_len;
  size_t last_aw_size;
  addr_t last_ar_addr;
  len_t  last_ar_len;
  size_t last_ar_size;
  // beats whose last flag was wrong
  int    last_bad = 0;

  // w beats may arrive ahead of aw
  data_t wq_data [$];
  strb_t wq_strb [$];
  logic  wq_last [$];

  logic  aw_pend = 1'b0;
  addr_t aw_addr_q;
  len_t  aw_len_q;
  id_t   aw_id_q;
  logic  b_pend = 1'b0;
  logic  b_taken = 1'b0;
  logic  r_act = 1'b0;
  logic  r_taken = 1'b0;
  int    r_base;
  len_t  r_len;
  int    r_beat;
  id_t   r_id_q;

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic take_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic int word_of(addr_t a);
    return int'(a[31:3]) % Words;
  endfunction

  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = {32'(i) ^ 32'h5a5a_0f0f, 32'(i) * 32'h0101_0101};
    end
    {aw_ready_o, ar_ready_o, w_ready_o, b_valid_o, r_valid_o, r_last_o} = '0;
    b_id_o   = '0;
    r_id_o   = '0;
    r_data_o = '0;
  end

  // --------------------------------------------------------------------------
  // outputs change on the falling edge only
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      {aw_ready_o, ar_ready_o, w_ready_o, b_valid_o, r_valid_o} = '0;
    end else begin
      // beats taken on the last rising edge leave the bus now
      if (b_taken) begin
        b_valid_o = 1'b0;
        b_taken   = 1'b0;
      end
      if (r_taken) begin
        r_valid_o = 1'b0;
        r_taken   = 1'b0;
      end
      aw_ready_o = take_bit();
      ar_ready_o = take_bit();
      w_ready_o  = take_bit();
      if (b_pend && !b_valid_o && take_bit()) begin
        b_valid_o = 1'b1;
        b_id_o    = aw_id_q;
      end
      if (r_act && !r_valid_o && take_bit()) begin
        r_valid_o = 1'b1;
        r_data_o  = mem[(r_base + r_beat) % Words];
        r_last_o  = (r_beat == int'(r_len));
        r_id_o    = r_id_q;
      end
    end
  end

  // --------------------------------------------------------------------------
  // handshakes on the rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      aw_pend      = 1'b1;
      aw_addr_q    = aw_addr_i;
      aw_len_q     = aw_len_i;
      aw_id_q      = aw_id_i;
      last_aw_addr = aw_addr_i;
      last_aw_len  = aw_len_i;
      last_aw_size = aw_size_i;
    end
    if (w_valid_i && w_ready_o) begin
      wq_data.push_back(w_data_i);
      wq_strb.push_back(w_strb_i);
      wq_last.push_back(w_last_i);
    end
    // commit the whole burst under the strobes once it is present
    if (aw_pend && wq_data.size() == int'(aw_len_q) + 1) begin
      for (int i = 0; i <= int'(aw_len_q); i++) begin
        for (int b = 0; b < 8; b++) begin
          if (wq_strb[i][b]) begin
            mem[(word_of(aw_addr_q) + i) % Words][8*b +: 8] = wq_data[i][8*b +: 8];
          end
        end
        if (wq_last[i] != (i == int'(aw_len_q))) begin
          last_bad++;
        end
      end
      wq_data.delete();
      wq_strb.delete();
      wq_last.delete();
      aw_pend = 1'b0;
      b_pend  = 1'b1;
    end
    if (b_valid_o && b_ready_i) begin
      b_taken = 1'b1;
      b_pend  = 1'b0;
    end
    if (ar_valid_i && ar_ready_o) begin
      r_act        = 1'b1;
      r_base       = word_of(ar_addr_i);
      r_len        = ar_len_i;
      r_beat       = 0;
      r_id_q       = ar_id_i;
      last_ar_addr = ar_addr_i;
      last_ar_len  = ar_len_i;
      last_ar_size = ar_size_i;
    end
    if (r_valid_o && r_ready_i) begin
      r_taken = 1'b1;
      if (r_last_o) begin
        r_act = 1'b0;
      end else begin
        r_beat++;
      end
    end
  end

endmodule

// File: bench/tb_axi_adapter.sv
// Adapter testbench

module tb_axi_adapter import bus_pkg::*; import adapter_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LineBeats = 4;
  localparam int unsigned Words     = 64;
  localparam int unsigned NumPairs  = 30;
  localparam int unsigned NumReq    = 2 * NumPairs;

  logic clk_i, rst_ni;
  logic req_i, we_i, gnt_o, valid_o, critical_word_valid_o;
  req_kind_e type_i;
  addr_t addr_i;
  size_t size_i;
  id_t   id_i, id_o;
  data_t [LineBeats-1:0] wdata_i, rdata_o;
  strb_t [LineBeats-1:0] be_i;
  data_t critical_word_o;
  logic  aw_valid_o, aw_ready_i, ar_valid_o, ar_ready_i;
  addr_t aw_addr_o, ar_addr_o;
  len_t  aw_len_o, ar_len_o;
  size_t aw_size_o, ar_size_o;
  id_t   aw_id_o, ar_id_o, b_id_i, r_id_i;
  logic  w_valid_o, w_ready_i, w_last_o, b_valid_i, b_ready_o;
  logic  r_valid_i, r_ready_o, r_last_i;
  data_t w_data_o, r_data_i;
  strb_t w_strb_o;

  logic [31:0] lfsr_q = 32'h77f6;
  data_t shadow [Words];
  int    gnt_total = 0;
  int    valid_total = 0;
  int    crit_seen = 0;
  data_t crit_last;
  data_t [LineBeats-1:0] rsp_line;
  id_t   rsp_id;

  tb_clock u_tb_clock (.clk_o(clk_i), .rst_no(rst_ni));

  axi_adapter #(.LineBeats(LineBeats)) u_axi_adapter (.*);

  axi_mem_model #(.Words(Words)) u_mem_model (
    .clk_i, .rst_ni,
    .aw_valid_i(aw_valid_o), .aw_ready_o(aw_ready_i), .aw_addr_i(aw_addr_o),
    .aw_len_i(aw_len_o), .aw_size_i(aw_size_o), .aw_id_i(aw_id_o),
    .ar_valid_i(ar_valid_o), .ar_ready_o(ar_ready_i), .ar_addr_i(ar_addr_o),
    .ar_len_i(ar_len_o), .ar_size_i(ar_size_o), .ar_id_i(ar_id_o),
    .w_valid_i(w_valid_o), .w_ready_o(w_ready_i), .w_data_i(w_data_o),
    .w_strb_i(w_strb_o), .w_last_i(w_last_o),
    .b_valid_o(b_valid_i), .b_ready_i(b_ready_o), .b_id_o(b_id_i),
    .r_valid_o(r_valid_i), .r_ready_i(r_ready_o), .r_data_o(r_data_i),
    .r_id_o(r_id_i), .r_last_o(r_last_i)
  );

  // --------------------------------------------------------------------------
  // random source and reference helpers
  // --------------------------------------------------------------------------

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [63:0] take_bits(int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic data_t merge_word(data_t old_w, data_t new_w, strb_t s);
    data_t m;
    m = old_w;
    for (int b = 0; b < 8; b++) begin
      if (s[b]) m[8*b +: 8] = new_w[8*b +: 8];
    end
    return m;
  endfunction

  task automatic report_fail(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      report_fail("data word differs");
    end
  endtask

  task automatic check_id(string name, id_t exp, id_t act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      report_fail("transaction id differs");
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      report_fail("burst address differs");
    end
  endtask

  task automatic check_len(string name, len_t exp, len_t act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      report_fail("burst length differs");
    end
  endtask

  task automatic check_size(string name, size_t exp, size_t act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      report_fail("burst size differs");
    end
  endtask

  task automatic check_line(string name, data_t [LineBeats-1:0] exp,
                            data_t [LineBeats-1:0] act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      report_fail("read line differs");
    end
  endtask

  task automatic check_idle_controls();
    if ({gnt_o, valid_o, critical_word_valid_o, aw_valid_o, w_valid_o,
         ar_valid_o, b_ready_o, r_ready_o} !== '0) begin
      report_fail("a control output is high before the first request");
    end
  endtask

  // --------------------------------------------------------------------------
  // monitor and watchdog
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (gnt_o) gnt_total++;
    if (valid_o) begin
      valid_total++;
      // response words and id belong to the valid cycle
      rsp_line = rdata_o;
      rsp_id   = id_o;
    end
    if (critical_word_valid_o) begin
      crit_seen++;
      crit_last = critical_word_o;
    end
  end

  initial begin
    repeat (NumReq * 400 + 20) @(posedge clk_i);
    report_fail("timeout, the adapter stopped answering");
  end

  // runs one request whose inputs are already set and returns at a falling edge
  task automatic run_req(output data_t [LineBeats-1:0] line, output id_t rid);
    int g0;
    int v0;
    @(negedge clk_i);
    g0        = gnt_total;
    v0        = valid_total;
    crit_seen = 0;
    req_i     = 1'b1;
    while (gnt_total == g0) @(negedge clk_i);
    req_i = 1'b0;
    if (valid_total != v0) begin
      report_fail("valid came before the grant");
    end
    while (valid_total == v0) @(negedge clk_i);
    line = rsp_line;
    rid  = rsp_id;
    repeat (2) @(negedge clk_i);
    if (gnt_total != g0 + 1 || valid_total != v0 + 1) begin
      report_fail("a request saw more than one grant or valid");
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    data_t [LineBeats-1:0] got;
    data_t [LineBeats-1:0] exp_line;
    id_t                   got_id;
    int                    word;
    int                    base;
    logic                  is_line;
    len_t                  exp_len;
    size_t                 exp_size;

    req_i   = 1'b0;
    type_i  = REQ_SINGLE;
    we_i    = 1'b0;
    addr_i  = '0;
    size_i  = '0;
    id_i    = '0;
    wdata_i = '0;
    be_i    = '0;
    for (int i = 0; i < Words; i++) begin
      shadow[i] = {32'(i) ^ 32'h5a5a_0f0f, 32'(i) * 32'h0101_0101};
    end

    // controls stay low through reset and a few idle cycles
    while (rst_ni !== 1'b1) begin
      @(negedge clk_i);
      check_idle_controls();
    end
    repeat (3) begin
      @(negedge clk_i);
      check_idle_controls();
    end

    for (int p = 0; p < NumPairs; p++) begin
      is_line = (take_bits(1) == 64'd1);
      word    = int'(take_bits(6));
      base    = is_line ? (word / LineBeats) * LineBeats : word;
      type_i  = is_line ? REQ_LINE : REQ_SINGLE;
      addr_i  = addr_t'(word * 8);
      size_i  = size_t'(take_bits(2));
      for (int j = 0; j < LineBeats; j++) begin
        wdata_i[j] = take_bits(64);
        be_i[j]    = strb_t'(take_bits(8));
      end
      exp_len  = is_line ? len_t'(LineBeats - 1) : len_t'(0);
      // a line always moves full 8-byte beats
      exp_size = is_line ? size_t'(3) : size_i;

      // write phase
      we_i = 1'b1;
      id_i = id_t'(take_bits(4));
      run_req(got, got_id);
      check_id("write id", id_i, got_id);
      check_addr("write address", addr_t'(base * 8), u_mem_model.last_aw_addr);
      check_len("write length", exp_len, u_mem_model.last_aw_len);
      check_size("write size", exp_size, u_mem_model.last_aw_size);
      if (is_line) begin
        for (int j = 0; j < LineBeats; j++) begin
          shadow[base + j] = merge_word(shadow[base + j], wdata_i[j], be_i[j]);
        end
      end else begin
        shadow[word] = merge_word(shadow[word], wdata_i[0], be_i[0]);
      end
      if (u_mem_model.last_bad != 0) begin
        report_fail("w_last was set on the wrong beat");
      end

      // read back the same place
      we_i = 1'b0;
      id_i = id_t'(take_bits(4));
      run_req(got, got_id);
      check_id("read id", id_i, got_id);
      check_addr("read address", addr_t'(base * 8), u_mem_model.last_ar_addr);
      check_len("read length", exp_len, u_mem_model.last_ar_len);
      check_size("read size", exp_size, u_mem_model.last_ar_size);
      if (is_line) begin
        for (int j = 0; j < LineBeats; j++) begin
          exp_line[j] = shadow[base + j];
        end
        check_line("line read", exp_line, got);
        if (crit_seen != 1) begin
          report_fail("line read did not give exactly one critical word");
        end
        check_data("critical word", shadow[word], crit_last);
      end else begin
        check_data("single read", shadow[word], got[0]);
        if (crit_seen != 0) begin
          report_fail("single read raised the critical word strobe");
        end
      end
    end

    if (gnt_total == NumReq && valid_total == NumReq) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_fail("grant or valid count differs from the request count");
    end
  end

endmodule

// File: bench/tb_clock.sv
// Bench clock and reset

module tb_clock #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the flops
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: common/adapter_pkg.sv
// Adapter request encodings

package adapter_pkg;

  // kind of request from the cache side
  // a single word, or a whole line moved as one burst
  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_e;

  // response channel the collector has to wait on
  typedef enum logic {
    RSP_WRITE = 1'b0,
    RSP_READ  = 1'b1
  } rsp_kind_e;

  // low address bits that select a byte inside one beat
  localparam int unsigned WordShift = 3;

endpackage

// File: common/bus_pkg.sv
// AXI bus field types

package bus_pkg;

  // --------------------------------------------------------------------------
  // bus widths
  // --------------------------------------------------------------------------

  // byte address
  localparam int unsigned AddrWidth = 32;
  // one beat on the data channels
  localparam int unsigned DataWidth = 64;
  // transaction id, echoed back on b and r
  localparam int unsigned IdWidth   = 4;

  // --------------------------------------------------------------------------
  // channel field types
  // --------------------------------------------------------------------------

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  // one enable bit per data byte
  typedef logic [DataWidth/8-1:0] strb_t;
  typedef logic [IdWidth-1:0]     id_t;

  // number of beats in the burst minus one
  typedef logic [7:0] len_t;

  // log2 of the bytes moved per beat
  typedef logic [2:0] size_t;

  // size code of a full beat, 8 bytes
  localparam size_t BeatSize = size_t'($clog2(DataWidth / 8));

endpackage

// File: project.f
common/bus_pkg.sv
common/adapter_pkg.sv
rtl/addr_issue.sv
rtl/write_streamer.sv
rtl/response_collect.sv
rtl/axi_adapter.sv
bench/tb_clock.sv
bench/axi_mem_model.sv
bench/tb_axi_adapter.sv

// File: rtl/addr_issue.sv
// Address channel request FSM

module addr_issue import bus_pkg::*; import adapter_pkg::*; #(
  parameter int unsigned LineBeats = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  req_kind_e                     type_i,
  input  logic                          we_i,
  input  addr_t                         addr_i,
  input  size_t                         size_i,
  input  id_t                           id_i,
  output logic                          gnt_o,
  output logic                          aw_valid_o,
  input  logic                          aw_ready_i,
  output addr_t                         aw_addr_o,
  output len_t                          aw_len_o,
  output size_t                         aw_size_o,
  output id_t                           aw_id_o,
  output logic                          ar_valid_o,
  input  logic                          ar_ready_i,
  output addr_t                         ar_addr_o,
  output len_t                          ar_len_o,
  output size_t                         ar_size_o,
  output id_t                           ar_id_o,
  output logic                          wr_start_o,
  output logic                          wr_line_o,
  output logic                          rsp_start_o,
  output rsp_kind_e                     rsp_kind_o,
  output logic                          rsp_line_o,
  output logic [$clog2(LineBeats)-1:0]  rsp_offset_o,
  input  logic                          rsp_done_i,
  input  logic                          wr_done_i
);

  localparam int unsigned BeatIdxW  = $clog2(LineBeats);
  // byte offset bits inside one line
  localparam int unsigned LineShift = WordShift + BeatIdxW;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WAIT_RSP
  } state_e;

  state_e state_q, state_d;
  // aw handshake and last w beat seen, in either order
  logic   aw_done_q, aw_done_d;
  logic   wr_done_q, wr_done_d;

  logic   is_line;
  addr_t  req_addr;
  len_t   req_len;
  size_t  req_size;

  // --------------------------------------------------------------------------
  // address channel payload
  // --------------------------------------------------------------------------
  assign is_line = (type_i == REQ_LINE);

  always_comb begin
    req_addr = addr_i;
    // a line burst starts at the line base
    if (is_line) begin
      req_addr[LineShift-1:0] = '0;
    end
  end

  assign req_len  = is_line ? len_t'(LineBeats - 1) : '0;
  assign req_size = is_line ? BeatSize : size_i;

  // aw and ar carry the same fields, only the valids differ
  assign aw_addr_o = req_addr;
  assign aw_len_o  = req_len;
  assign aw_size_o = req_size;
  assign aw_id_o   = id_i;
  assign ar_addr_o = req_addr;
  assign ar_len_o  = req_len;
  assign ar_size_o = req_size;
  assign ar_id_o   = id_i;

  // request inputs are held until grant, so these are stable at rsp_start
  assign wr_line_o    = is_line;
  assign rsp_kind_o   = we_i ? RSP_WRITE : RSP_READ;
  assign rsp_line_o   = is_line;
  assign rsp_offset_o = addr_i[WordShift +: BeatIdxW];

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    aw_done_d   = aw_done_q;
    wr_done_d   = wr_done_q;
    gnt_o       = 1'b0;
    aw_valid_o  = 1'b0;
    ar_valid_o  = 1'b0;
    wr_start_o  = 1'b0;
    rsp_start_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        aw_done_d = 1'b0;
        wr_done_d = 1'b0;
        if (req_i && we_i) begin
          // kick the streamer, aw may already go through this cycle
          wr_start_o = 1'b1;
          aw_valid_o = 1'b1;
          aw_done_d  = aw_ready_i;
          state_d    = ST_WRITE;
        end else if (req_i) begin
          // reads are granted straight off the ar handshake
          ar_valid_o = 1'b1;
          gnt_o      = ar_ready_i;
          if (ar_ready_i) begin
            rsp_start_o = 1'b1;
            state_d     = ST_WAIT_RSP;
          end
        end
      end

      ST_WRITE: begin
        aw_valid_o = !aw_done_q;
        if (aw_ready_i) begin
          aw_done_d = 1'b1;
        end
        if (wr_done_i) begin
          wr_done_d = 1'b1;
        end
        // grant on the later of the two handshakes
        if (aw_done_d && wr_done_d) begin
          gnt_o       = 1'b1;
          rsp_start_o = 1'b1;
          state_d     = ST_WAIT_RSP;
        end
      end

      ST_WAIT_RSP: begin
        if (rsp_done_i) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      wr_done_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      wr_done_q <= wr_done_d;
    end
  end

endmodule

// File: rtl/axi_adapter.sv
// Cache to AXI bus adapter

module axi_adapter import bus_pkg::*; import adapter_pkg::*; #(
  parameter int unsigned LineBeats = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // cache request side
  input  logic                  req_i,
  input  req_kind_e             type_i,
  input  logic                  we_i,
  input  addr_t                 addr_i,
  input  size_t                 size_i,
  input  id_t                   id_i,
  input  data_t [LineBeats-1:0] wdata_i,
  input  strb_t [LineBeats-1:0] be_i,
  output logic                  gnt_o,
  output logic                  valid_o,
  output data_t [LineBeats-1:0] rdata_o,
  output id_t                   id_o,
  output data_t                 critical_word_o,
  output logic                  critical_word_valid_o,
  // write address channel
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output addr_t                 aw_addr_o,
  output len_t                  aw_len_o,
  output size_t                 aw_size_o,
  output id_t                   aw_id_o,
  // read address channel
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addr_t                 ar_addr_o,
  output len_t                  ar_len_o,
  output size_t                 ar_size_o,
  output id_t                   ar_id_o,
  // write data channel
  output logic                  w_valid_o,
  input  logic                  w_ready_i,
  output data_t                 w_data_o,
  output strb_t                 w_strb_o,
  output logic                  w_last_o,
  // write response channel
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  input  id_t                   b_id_i,
  // read data channel
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  input  data_t                 r_data_i,
  input  id_t                   r_id_i,
  input  logic                  r_last_i
);

  localparam int unsigned BeatIdxW = $clog2(LineBeats);

  // handoff between the stages
  logic                wr_start;
  logic                wr_line;
  logic                wr_done;
  logic                rsp_start;
  rsp_kind_e           rsp_kind;
  logic                rsp_line;
  logic [BeatIdxW-1:0] rsp_offset;
  logic                rsp_done;

  // --------------------------------------------------------------------------
  // stage 1: address issue and grant
  // --------------------------------------------------------------------------
  addr_issue #(
    .LineBeats (LineBeats)
  ) u_addr_issue (
    .wr_start_o   (wr_start),
    .wr_line_o    (wr_line),
    .wr_done_i    (wr_done),
    .rsp_start_o  (rsp_start),
    .rsp_kind_o   (rsp_kind),
    .rsp_line_o   (rsp_line),
    .rsp_offset_o (rsp_offset),
    .rsp_done_i   (rsp_done),
    .*
  );

  // --------------------------------------------------------------------------
  // stage 2: write beats
  // --------------------------------------------------------------------------
  write_streamer #(
    .LineBeats (LineBeats)
  ) u_write_streamer (
    .wr_start_i (wr_start),
    .wr_line_i  (wr_line),
    .wr_done_o  (wr_done),
    .*
  );

  // --------------------------------------------------------------------------
  // stage 3: b and r collection
  // --------------------------------------------------------------------------
  response_collect #(
    .LineBeats (LineBeats)
  ) u_response_collect (
    .rsp_start_i  (rsp_start),
    .rsp_kind_i   (rsp_kind),
    .rsp_line_i   (rsp_line),
    .rsp_offset_i (rsp_offset),
    .rsp_done_o   (rsp_done),
    .*
  );

endmodule

// File: rtl/response_collect.sv
// Write response and read beat collector

module response_collect import bus_pkg::*; import adapter_pkg::*; #(
  parameter int unsigned LineBeats = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rsp_start_i,
  input  rsp_kind_e                     rsp_kind_i,
  input  logic                          rsp_line_i,
  input  logic [$clog2(LineBeats)-1:0]  rsp_offset_i,
  input  logic                          b_valid_i,
  output logic                          b_ready_o,
  input  id_t                           b_id_i,
  input  logic                          r_valid_i,
  output logic                          r_ready_o,
  input  data_t                         r_data_i,
  input  id_t                           r_id_i,
  input  logic                          r_last_i,
  output logic                          valid_o,
  output data_t [LineBeats-1:0]         rdata_o,
  output id_t                           id_o,
  output data_t                         critical_word_o,
  output logic                          critical_word_valid_o,
  output logic                          rsp_done_o
);

  localparam int unsigned BeatIdxW = $clog2(LineBeats);

  // control state
  logic                  busy_q;
  rsp_kind_e             kind_q;
  logic                  line_q;
  logic [BeatIdxW-1:0]   cnt_q;
  // last read beat moved in the previous cycle
  logic                  rd_done_q;

  // payload
  logic [BeatIdxW-1:0]   offset_q;
  id_t                   id_q;
  data_t [LineBeats-1:0] line_data_q;

  logic                  b_hs;
  logic                  r_hs;
  logic [BeatIdxW-1:0]   beat_idx;

  // --------------------------------------------------------------------------
  // channel handshakes
  // --------------------------------------------------------------------------
  assign b_ready_o = busy_q && (kind_q == RSP_WRITE);
  assign r_ready_o = busy_q && (kind_q == RSP_READ);
  assign b_hs      = b_ready_o && b_valid_i;
  assign r_hs      = r_ready_o && r_valid_i;

  // single reads land in word 0
  assign beat_idx = line_q ? cnt_q : '0;

  // write completes with b, read completes a cycle after its last beat
  assign valid_o    = b_hs || rd_done_q;
  assign rsp_done_o = valid_o;
  assign rdata_o    = line_data_q;
  // b id goes straight out while b is being taken
  assign id_o       = b_ready_o ? b_id_i : id_q;

  // the word the cache missed on, forwarded as soon as it shows up
  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = r_hs && line_q && (cnt_q == offset_q);

  // --------------------------------------------------------------------------
  // control registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      kind_q    <= RSP_WRITE;
      line_q    <= 1'b0;
      cnt_q     <= '0;
      rd_done_q <= 1'b0;
    end else begin
      rd_done_q <= r_hs && r_last_i;
      if (rsp_start_i) begin
        busy_q <= 1'b1;
        kind_q <= rsp_kind_i;
        line_q <= rsp_line_i;
        cnt_q  <= '0;
      end else if (b_hs || (r_hs && r_last_i)) begin
        busy_q <= 1'b0;
      end else if (r_hs) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // line buffer, offset and id
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rsp_start_i) begin
      offset_q <= rsp_offset_i;
    end
    if (r_hs) begin
      line_data_q[beat_idx] <= r_data_i;
    end
    // id is taken from b or from the closing r beat
    if (b_hs) begin
      id_q <= b_id_i;
    end else if (r_hs && r_last_i) begin
      id_q <= r_id_i;
    end
  end

endmodule

// File: rtl/write_streamer.sv
// Write data beat streamer

module write_streamer import bus_pkg::*; #(
  parameter int unsigned LineBeats = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wr_start_i,
  input  logic                  wr_line_i,
  input  data_t [LineBeats-1:0] wdata_i,
  input  strb_t [LineBeats-1:0] be_i,
  output logic                  w_valid_o,
  input  logic                  w_ready_i,
  output data_t                 w_data_o,
  output strb_t                 w_strb_o,
  output logic                  w_last_o,
  output logic                  wr_done_o
);

  localparam int unsigned BeatIdxW = $clog2(LineBeats);

  logic                busy_q;
  logic                line_q;
  // index of the word on the bus
  logic [BeatIdxW-1:0] cnt_q;
  logic                beat_hs;

  // --------------------------------------------------------------------------
  // beat select
  // --------------------------------------------------------------------------

  // a single write never moves the counter off word 0
  assign w_valid_o = busy_q;
  assign w_data_o  = wdata_i[cnt_q];
  assign w_strb_o  = be_i[cnt_q];
  assign w_last_o  = busy_q && (!line_q || (cnt_q == BeatIdxW'(LineBeats - 1)));

  assign beat_hs   = w_valid_o && w_ready_i;
  // same cycle as the last handshake, so the grant is not delayed
  assign wr_done_o = beat_hs && w_last_o;

  // --------------------------------------------------------------------------
  // beat counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      line_q <= 1'b0;
      cnt_q  <= '0;
    end else if (wr_start_i) begin
      // w_valid comes up the next cycle
      busy_q <= 1'b1;
      line_q <= wr_line_i;
      cnt_q  <= '0;
    end else if (beat_hs) begin
      if (w_last_o) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the adapter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f project.f \
  --top-module tb_axi_adapter -o sim_tb > build.log 2>&1 \
  || { cat build.log; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
! grep -q "Something failed" sim.log && grep -q "Everything OK" sim.log || exit 1
